/* sim.f */
+incdir+design
design/board_pkg.sv
design/move_pkg.sv
design/move_fifo.sv
design/square_port_if.sv
design/square_unit.sv
design/column_collector.sv
design/column_unit.sv
sim/column_unit_tb.sv

/* Bender.yml */
package:
  name: column_unit

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/board_pkg.sv
      - design/move_pkg.sv
      - design/move_fifo.sv
      - design/square_port_if.sv
      - design/square_unit.sv
      - design/column_collector.sv
      - design/column_unit.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/column_unit_tb.sv

/* sim/column_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "move_defines.svh"

module column_unit_tb
	import board_pkg::*, move_pkg::*;
();

	localparam int TIMEOUT = 400;
	localparam logic [31:0] SEED = 32'd83444;
	// taps for x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] POLY = 32'h80200003;

	typedef move_t move_q_t [$];

	logic clk = 1'b0;
	logic reset;
	logic start;
	col_state_t col_state;
	file_t xpos;
	logic rden;
	move_t move_out;
	logic fifo_empty;
	logic done;

	// separate streams for columns and read gaps
	logic [31:0] col_lfsr = SEED;
	logic [31:0] gap_lfsr = SEED;
	int read_mode;
	move_q_t exp_q;
	int got_n;
	int errors = 0;
	int timeouts = 0;
	int checks = 0;

	column_unit dut0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.col_state(col_state),
		.xpos(xpos),
		.rden(rden),
		.move_out(move_out),
		.fifo_empty(fifo_empty),
		.done(done)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ POLY) : (s >> 1);
	endfunction

	// one lfsr step per bit
	function automatic logic [7:0] col_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			col_lfsr = lfsr_next(col_lfsr);
			v = {v[6:0], col_lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic is_empty(input piece_t p);
		return p[2:0] == `PC_EMPTY;
	endfunction

	function automatic move_t make_move(input int from, input int to, input file_t x,
		input logic pawn, input logic two, input logic cap);
		move_t m;
		m = '0;
		m.flags.pawn_move = pawn;
		m.flags.pawn_2sq = two;
		m.flags.capture = cap;
		m.flags.promote = pawn && (to == `BOARD_ROWS - 1);
		m.from_sq.row = row_t'(from);
		m.from_sq.file = x;
		m.to_sq.row = row_t'(to);
		m.to_sq.file = x;
		return m;
	endfunction

	// expected stream, row 8 down to row 1, up ray before down ray
	function automatic move_q_t ref_moves(input col_state_t cs, input file_t x);
		move_q_t q;
		kind_t k;
		int t;
		q = {};
		for (int r = `BOARD_ROWS - 1; r >= 0; r--) begin
			k = cs[r][2:0];
			if (cs[r][`PC_BLACK_BIT])
				continue;
			if (k == `PC_PAWN) begin
				if (r < `BOARD_ROWS - 1 && is_empty(cs[r+1])) begin
					q.push_back(make_move(r, r + 1, x, 1'b1, 1'b0, 1'b0));
					if (r == 1 && is_empty(cs[3]))
						q.push_back(make_move(r, 3, x, 1'b1, 1'b1, 1'b0));
				end
			end else if (k == `PC_ROOK || k == `PC_QUEEN || k == `PC_KING) begin
				for (int dir = 1; dir >= -1; dir -= 2) begin
					t = r + dir;
					while (t >= 0 && t < `BOARD_ROWS) begin
						if (!is_empty(cs[t])) begin
							if (cs[t][`PC_BLACK_BIT])
								q.push_back(make_move(r, t, x, 1'b0, 1'b0, 1'b1));
							break;
						end
						q.push_back(make_move(r, t, x, 1'b0, 1'b0, 1'b0));
						if (k == `PC_KING)
							break;
						t = t + dir;
					end
				end
			end
		end
		return q;
	endfunction

	task automatic random_column(output col_state_t cs, output file_t x);
		kind_t kind;
		logic color;
		for (int r = 0; r < `BOARD_ROWS; r++) begin
			kind = kind_t'(col_bits(3));
			color = (col_bits(1) != 8'd0);
			cs[r] = (kind == 3'd7) ? 4'h0 : {color, kind};
		end
		x = file_t'(col_bits(3));
	endtask

	task automatic check_idle(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			checks++;
			assert (done === 1'b0)
				else begin
					$display("ERR done expected %h actual %h", 1'b0, done);
					errors++;
				end
			assert (fifo_empty === 1'b1)
				else begin
					$display("ERR fifo_empty expected %h actual %h", 1'b1, fifo_empty);
					errors++;
				end
		end
	endtask

	// mode 0 reads every cycle, 1 with random gaps, 2 holds until done
	task automatic run_column(input col_state_t cs, input file_t x, input int mode);
		int n_exp;
		int cycles;
		if (timeouts != 0)
			return;
		read_mode = mode;
		@(posedge clk);
		#1;
		exp_q = ref_moves(cs, x);
		n_exp = exp_q.size();
		got_n = 0;
		col_state = cs;
		xpos = x;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		cycles = 0;
		@(negedge clk);
		while (!(done && fifo_empty) && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (cycles >= TIMEOUT) begin
			$display("timeout: column at file %0d did not drain in %0d cycles", x, TIMEOUT);
			timeouts++;
		end else begin
			checks++;
			assert (got_n == n_exp)
				else begin
					$display("ERR move count expected %h actual %h", n_exp, got_n);
					errors++;
				end
		end
	endtask

	// reader
	always @(posedge clk) begin
		#1;
		if (read_mode == 0) begin
			rden = 1'b1;
		end else if (read_mode == 1 || done) begin
			gap_lfsr = lfsr_next(gap_lfsr);
			rden = gap_lfsr[0];
		end else begin
			rden = 1'b0;
		end
	end

	// a pop happens on the next rising edge
	always @(negedge clk) begin : compare
		move_t expd;
		if (!reset && rden && !fifo_empty) begin
			got_n++;
			assert (exp_q.size() != 0)
				else begin
					$display("extra move %h popped after the expected list ran out", move_out);
					errors++;
				end
			if (exp_q.size() != 0) begin
				expd = exp_q.pop_front();
				checks++;
				assert (move_out === expd)
					else begin
						$display("ERR move_out expected %h actual %h", expd, move_out);
						errors++;
					end
			end
		end
	end

	initial begin : main
		col_state_t cs;
		file_t x;
		reset = 1'b1;
		start = 1'b0;
		col_state = '0;
		xpos = '0;
		rden = 1'b0;
		read_mode = 2;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		check_idle(20);

		// no movers at all
		run_column('0, 3'd0, 0);
		cs = {4'hC, 4'hB, 4'hD, 4'hE, 4'h9, 4'hC, 4'hD, 4'hE};
		run_column(cs, 3'd5, 1);

		// double push from row 2
		cs = '0;
		cs[1] = 4'h1;
		run_column(cs, 3'd2, 0);
		// push blocked by a black knight
		cs = '0;
		cs[1] = 4'h1;
		cs[2] = 4'hA;
		run_column(cs, 3'd7, 0);
		// promotion from row 7
		cs = '0;
		cs[6] = 4'h1;
		run_column(cs, 3'd4, 1);
		// king between two black pieces
		cs = '0;
		cs[4] = 4'h6;
		cs[5] = 4'hC;
		cs[3] = 4'hB;
		run_column(cs, 3'd1, 0);

		// reader stalls until the collector is done
		cs = '0;
		cs[0] = 4'h4;
		cs[7] = 4'h5;
		cs[3] = 4'h6;
		run_column(cs, 3'd6, 2);

		// back to back starts, each column replaces the last
		for (int i = 0; i < 200; i++) begin
			random_column(cs, x);
			run_column(cs, x, i % 3);
		end

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* design/column_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "move_defines.svh"

// one board column: eight square units feeding one column fifo
module column_unit
	import board_pkg::*, move_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire col_state_t col_state,
	input wire file_t xpos,
	input wire logic rden,
	output move_t move_out,
	output logic fifo_empty,
	output logic done
);

	logic col_wr_en;
	move_t col_wr_data;
	logic col_full;

	square_port_if sq_if [`BOARD_ROWS] ();

	// index g sits on row g+1
	for (genvar g = 0; g < `BOARD_ROWS; g++) begin : g_sq
		square_unit #(
			.SQ_ROW(g)
		) u_sq (
			.clk(clk),
			.reset(reset),
			.start(start),
			.col_state(col_state),
			.port(sq_if[g])
		);
	end

	column_collector u_collector (
		.clk(clk),
		.reset(reset),
		.start(start),
		.xpos(xpos),
		.sq(sq_if),
		.col_wr_en(col_wr_en),
		.col_wr_data(col_wr_data),
		.col_full(col_full),
		.done(done)
	);

	// pops on an empty fifo are dropped
	move_fifo #(
		.payload_t(move_t),
		.DEPTH(`COL_FIFO_DEPTH)
	) u_col_fifo (
		.clk(clk),
		.reset(reset),
		.wr_en(col_wr_en),
		.wr_data(col_wr_data),
		.rd_en(rden && !fifo_empty),
		.rd_data(move_out),
		.empty(fifo_empty),
		.full(col_full)
	);

endmodule

`default_nettype wire

/* design/column_collector.sv */
`timescale 1ns/1ns
`default_nettype none

`include "move_defines.svh"

// drains the square fifos in row order 8 down to 1
module column_collector
	import board_pkg::*, move_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire file_t xpos,
	square_port_if.collector sq [`BOARD_ROWS],
	output logic col_wr_en,
	output move_t col_wr_data,
	input wire logic col_full,
	output logic done
);

	typedef enum logic [1:0] {
		WAIT = 2'b01,
		GETM = 2'b11,
		DONE = 2'b10
	} coll_state_t;

	coll_state_t state;
	logic [`BOARD_ROWS-1:0] moved;
	row_t ptr;
	row_t pick;

	logic [`BOARD_ROWS-1:0] sq_done;
	logic [`BOARD_ROWS-1:0] sq_empty;
	logic [`BOARD_ROWS-1:0] rden_vec;
	sq_move_t sq_move [`BOARD_ROWS];
	sq_move_t head;

	// interface arrays only take constant indices
	for (genvar g = 0; g < `BOARD_ROWS; g++) begin : g_port
		assign sq_done[g] = sq[g].done;
		assign sq_empty[g] = sq[g].empty;
		assign sq_move[g] = sq[g].move;
		assign sq[g].rden = rden_vec[g];
	end

	// highest row not yet moved
	always_comb begin
		pick = '0;
		for (int i = 0; i < `BOARD_ROWS; i++) begin
			if (!moved[i])
				pick = row_t'(i);
		end
	end

	assign head = sq_move[ptr];

	always_comb begin
		rden_vec = '0;
		if (state == GETM && !sq_empty[ptr] && !col_full)
			rden_vec[ptr] = 1'b1;
	end

	assign col_wr_en = |rden_vec;

	always_comb begin
		col_wr_data.flags = head.flags;
		col_wr_data.from_sq.row = ptr;
		col_wr_data.from_sq.file = xpos;
		col_wr_data.to_sq.row = head.to_row;
		col_wr_data.to_sq.file = xpos;
	end

	assign done = (state == DONE);

	always_ff @(posedge clk) begin
		if (reset || start) begin
			state <= WAIT;
			moved <= '0;
			ptr <= '0;
		end else begin
			case (state)
				WAIT: begin
					if (&moved) begin
						state <= DONE;
					end else if (sq_done[pick]) begin
						// done and empty, nothing to fetch
						if (sq_empty[pick]) begin
							moved[pick] <= 1'b1;
						end else begin
							ptr <= pick;
							state <= GETM;
						end
					end
				end
				GETM: begin
					if (sq_empty[ptr]) begin
						moved[ptr] <= 1'b1;
						state <= WAIT;
					end
				end
				default: ;
			endcase
		end
	end

	a_one_pop: assert property (@(posedge clk) disable iff (reset) $onehot0(rden_vec))
		else $error("column_collector: more than one square popped");
	a_no_full_write: assert property (@(posedge clk) disable iff (reset)
		col_wr_en |-> !col_full)
		else $error("column_collector: write into full column fifo");

endmodule

`default_nettype wire

/* design/square_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "move_defines.svh"

// enumerates the in-column moves of a white piece on one square
module square_unit
	import board_pkg::*, move_pkg::*;
#(
	parameter int SQ_ROW = 0
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire col_state_t col_state,
	square_port_if.square port
);

	localparam row_t HOME = row_t'(SQ_ROW);
	localparam row_t TOP_ROW = row_t'(`BOARD_ROWS - 1);

	typedef enum logic [1:0] {S_IDLE, S_UP, S_DOWN, S_NONE} scan_state_t;

	scan_state_t state;
	row_t cur;
	logic first;
	kind_t kind_q;
	logic done_q;

	piece_t own;
	kind_t own_kind;
	row_t target;
	piece_t tp;
	logic t_empty;
	logic t_black;
	logic is_pawn;
	logic is_king;
	logic scanning;
	logic ray_more;
	logic wr_en;
	sq_move_t wr_data;

	function automatic logic up_kind(input kind_t k);
		return (HOME != TOP_ROW) &&
			(k == `PC_PAWN || k == `PC_ROOK || k == `PC_QUEEN || k == `PC_KING);
	endfunction

	// pawns never move down
	function automatic logic down_kind(input kind_t k);
		return (HOME != 3'd0) && (k == `PC_ROOK || k == `PC_QUEEN || k == `PC_KING);
	endfunction

	assign own = col_state[HOME];
	// anything but a white piece is treated as no mover
	assign own_kind = (!own[`PC_BLACK_BIT]) ? own[2:0] : `PC_EMPTY;

	assign scanning = (state == S_UP) || (state == S_DOWN);
	assign target = (state == S_UP) ? cur + 1'b1 : cur - 1'b1;
	assign tp = col_state[target];
	assign t_empty = (tp[2:0] == `PC_EMPTY);
	assign t_black = tp[`PC_BLACK_BIT] && !t_empty;
	assign is_pawn = (kind_q == `PC_PAWN);
	assign is_king = (kind_q == `PC_KING);

	// pawns push only onto empty squares
	assign wr_en = scanning && (t_empty || (t_black && !is_pawn));

	always_comb begin
		wr_data = '0;
		wr_data.to_row = target;
		wr_data.flags.capture = t_black;
		wr_data.flags.pawn_move = is_pawn;
		wr_data.flags.pawn_2sq = is_pawn && !first;
		wr_data.flags.promote = is_pawn && (target == TOP_ROW);
	end

	// second pawn step only from row 2, kings take one step
	assign ray_more = t_empty && !is_king &&
		(!is_pawn || (first && HOME == 3'd1)) &&
		((state == S_UP) ? (target != TOP_ROW) : (target != 3'd0));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			done_q <= 1'b0;
			cur <= HOME;
			first <= 1'b1;
			kind_q <= `PC_EMPTY;
		end else if (start) begin
			done_q <= 1'b0;
			cur <= HOME;
			first <= 1'b1;
			kind_q <= own_kind;
			if (up_kind(own_kind))
				state <= S_UP;
			else if (down_kind(own_kind))
				state <= S_DOWN;
			else
				state <= S_NONE;
		end else begin
			case (state)
				S_UP, S_DOWN: begin
					if (ray_more) begin
						cur <= target;
						first <= 1'b0;
					end else if (state == S_UP && down_kind(kind_q)) begin
						state <= S_DOWN;
						cur <= HOME;
						first <= 1'b1;
					end else begin
						state <= S_IDLE;
						done_q <= 1'b1;
					end
				end
				// nothing to scan, still one cycle
				S_NONE: begin
					state <= S_IDLE;
					done_q <= 1'b1;
				end
				default: ;
			endcase
		end
	end

	assign port.done = done_q;

	move_fifo #(
		.payload_t(sq_move_t),
		.DEPTH(`SQ_FIFO_DEPTH)
	) u_sq_fifo (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.rd_en(port.rden),
		.rd_data(port.move),
		.empty(port.empty),
		.full()
	);

	// collector relies on done holding until the next start
	a_done_hold: assert property (@(posedge clk) disable iff (reset)
		$fell(done_q) |-> ($past(start) || $past(reset)))
		else $error("square_unit: done fell without start");

endmodule

`default_nettype wire

/* design/square_port_if.sv */
`timescale 1ns/1ns
`default_nettype none

// link from one square unit to the collector
interface square_port_if
	import move_pkg::*;
();

	// head of the square fifo, valid while empty is low
	sq_move_t move;
	logic empty;
	// level, high once the square has finished
	logic done;
	// one-cycle pop
	logic rden;

	modport square (
		output move,
		output empty,
		output done,
		input rden
	);

	modport collector (
		input move,
		input empty,
		input done,
		output rden
	);

endinterface

`default_nettype wire

/* design/move_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

// circular buffer with a show-ahead read port
module move_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 8
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic wr_en,
	input wire payload_t wr_data,
	input wire logic rd_en,
	output payload_t rd_data,
	output logic empty,
	output logic full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;

	// wrap at DEPTH, which need not be a power of two
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full = (count == CW'(DEPTH));
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= next_ptr(wr_ptr);
			if (rd_en)
				rd_ptr <= next_ptr(rd_ptr);
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
	end

	// writer and reader must respect the flags
	a_no_overflow: assert property (@(posedge clk) disable iff (reset) wr_en |-> !full)
		else $error("move_fifo: write while full");
	a_no_underflow: assert property (@(posedge clk) disable iff (reset) rd_en |-> !empty)
		else $error("move_fifo: read while empty");

endmodule

`default_nettype wire

/* design/move_pkg.sv */
`default_nettype none

package move_pkg;
	import board_pkg::*;

	// castle and en_passant stay 0 inside a single column
	typedef struct packed {
		logic invalid;
		logic promote;
		logic pawn_move;
		logic pawn_2sq;
		logic en_passant;
		logic castle;
		logic capture;
	} move_flags_t;

	// square fifo entry, the from row is implied by the square
	typedef struct packed {
		move_flags_t flags;
		row_t to_row;
	} sq_move_t;

	typedef struct packed {
		row_t row;
		file_t file;
	} sq_addr_t;

	// column fifo entry, same bit order as move_out
	typedef struct packed {
		move_flags_t flags;
		sq_addr_t from_sq;
		sq_addr_t to_sq;
	} move_t;

endpackage

`default_nettype wire

/* design/board_pkg.sv */
`default_nettype none

`include "move_defines.svh"

package board_pkg;

	// bit 3 is the color, bits 2..0 the piece type
	typedef logic [3:0] piece_t;

	typedef logic [2:0] kind_t;

	// row index, 0 is row 1
	typedef logic [2:0] row_t;

	// file index of the column
	typedef logic [2:0] file_t;

	// index 7 holds row 8, index 0 (low nibble) holds row 1
	typedef piece_t [`BOARD_ROWS-1:0] col_state_t;

endpackage

`default_nettype wire

/* design/move_defines.svh */
`ifndef MOVE_DEFINES_SVH
`define MOVE_DEFINES_SVH

// board geometry
`define BOARD_ROWS 8

// one square has at most 7 vertical moves
`define SQ_FIFO_DEPTH 8
// whole column, deep enough for every square at once
`define COL_FIFO_DEPTH 64

// piece type codes, low three bits of a piece
`define PC_EMPTY 3'd0
`define PC_PAWN 3'd1
`define PC_KNIGHT 3'd2
`define PC_BISHOP 3'd3
`define PC_ROOK 3'd4
`define PC_QUEEN 3'd5
`define PC_KING 3'd6

// color bit of a piece, set for black
`define PC_BLACK_BIT 3

`endif
